// ==== design/display_pkg.sv ====
// sizes, timing constants and types shared by the seven-segment display design
// referenced by scoped names from every design and testbench file

package display_pkg;

	localparam int NUM_DIGITS     = 4;
	localparam int VALUE_WIDTH    = 16;
	localparam int MAX_DISPLAY    = 9999;
	localparam int CONVERT_CYCLES = 16; // one shift per input bit
	localparam int SCAN_TICKS     = 8; // short so a full scan fits in a quick simulation

	localparam int ACC_DIGITS        = NUM_DIGITS + 1; // extra digit catches overflow
	localparam int COUNT_WIDTH       = $clog2(CONVERT_CYCLES + 1);
	localparam int SCAN_TICK_WIDTH   = $clog2(SCAN_TICKS);
	localparam int DIGIT_INDEX_WIDTH = $clog2(NUM_DIGITS);

	typedef logic [3:0] bcd_digit_t;

	// index 0 is the least significant digit
	typedef bcd_digit_t [NUM_DIGITS-1:0] bcd_digits_t;

	// bit 0 is segment a, bit 6 is segment g, active high
	typedef logic [6:0] seg_t;

	localparam bcd_digit_t BCD_BLANK = 4'hf; // any code above 9 decodes to blank

	localparam seg_t SEG_BLANK = 7'b000_0000;
	localparam seg_t SEG_DASH  = 7'b100_0000; // middle bar only

endpackage

// ==== design/bcd_if.sv ====
// carries converted decimal digits from the converter to the scanner
// digits and overflow are valid while done is high and held until the next done

`timescale 1ns/1ps

interface bcd_if;

	display_pkg::bcd_digits_t digits; // low four decimal digits
	logic overflow; // value above what four digits can show
	logic done; // one-cycle strobe, new result
	logic busy; // conversion in progress

	modport source (
		output digits,
		output overflow,
		output done,
		output busy
	);

	modport sink (
		input digits,
		input overflow,
		input done
	);

endinterface

// ==== design/seven_seg_decoder.sv ====
// maps one decimal digit to its seven-segment pattern
// codes above nine give an unlit digit, which the scanner uses for blanking

`timescale 1ns/1ps

module seven_seg_decoder (
	input  display_pkg::bcd_digit_t digit,
	output display_pkg::seg_t pattern
);

	always_comb begin
		case (digit)
			4'd0: begin
				pattern = 7'b011_1111; // a b c d e f
			end
			4'd1: begin
				pattern = 7'b000_0110; // b c
			end
			4'd2: begin
				pattern = 7'b101_1011; // a b d e g
			end
			4'd3: begin
				pattern = 7'b100_1111; // a b c d g
			end
			4'd4: begin
				pattern = 7'b110_0110; // b c f g
			end
			4'd5: begin
				pattern = 7'b110_1101; // a c d f g
			end
			4'd6: begin
				pattern = 7'b111_1101; // a c d e f g
			end
			4'd7: begin
				pattern = 7'b000_0111; // a b c
			end
			4'd8: begin
				pattern = 7'b111_1111; // everything lit
			end
			4'd9: begin
				pattern = 7'b110_1111; // a b c d f g
			end
			default: begin
				pattern = display_pkg::SEG_BLANK; // blank code and unused codes
			end
		endcase
	end

endmodule

// ==== design/bin2bcd_converter.sv ====
// sequential binary to BCD converter using shift and add-three
// a load while idle starts a conversion, done pulses once the digits are ready

`timescale 1ns/1ps

module bin2bcd_converter (
	input  logic CLK,
	input  logic reset,
	input  logic [display_pkg::VALUE_WIDTH-1:0] value,
	input  logic load,
	bcd_if.source out_bcd
);

	logic busy; // conversion running
	logic done_pulse; // result strobe
	logic [display_pkg::COUNT_WIDTH-1:0] shift_count; // shifts done so far
	logic [display_pkg::VALUE_WIDTH-1:0] shift_reg; // binary bits still to go in
	logic [4*display_pkg::ACC_DIGITS-1:0] acc; // five digit BCD accumulator
	logic [4*display_pkg::ACC_DIGITS-1:0] acc_adjusted; // accumulator after add-three
	display_pkg::bcd_digits_t digits_out; // held result
	logic overflow_out;
	logic accept; // load taken this cycle
	logic shifting; // a shift happens this cycle
	logic finishing; // last cycle of the conversion

	assign accept    = load && !busy; // loads while busy are dropped
	assign shifting  = busy && (shift_count < display_pkg::COUNT_WIDTH'(display_pkg::CONVERT_CYCLES));
	assign finishing = busy && !shifting;

	// add three to every digit of five or more before it is doubled
	always_comb begin
		for (int i = 0; i < display_pkg::ACC_DIGITS; i++) begin
			if (acc[4*i +: 4] >= 4'd5) begin
				acc_adjusted[4*i +: 4] = acc[4*i +: 4] + 4'd3;
			end else begin
				acc_adjusted[4*i +: 4] = acc[4*i +: 4];
			end
		end
	end

	// control state
	always_ff @(posedge CLK) begin
		if (reset) begin
			busy        <= 1'b0;
			done_pulse  <= 1'b0;
			shift_count <= '0;
		end else begin
			done_pulse <= 1'b0;
			if (accept) begin
				busy        <= 1'b1;
				shift_count <= '0;
			end else if (shifting) begin
				shift_count <= shift_count + 1'b1;
			end else if (finishing) begin
				busy       <= 1'b0; // falls together with done
				done_pulse <= 1'b1;
			end
		end
	end

	// datapath, msb of the value enters the accumulator first
	always_ff @(posedge CLK) begin
		if (accept) begin
			shift_reg <= value;
			acc       <= '0;
		end else if (shifting) begin
			acc       <= {acc_adjusted[4*display_pkg::ACC_DIGITS-2:0],
				shift_reg[display_pkg::VALUE_WIDTH-1]};
			shift_reg <= {shift_reg[display_pkg::VALUE_WIDTH-2:0], 1'b0};
		end else if (finishing) begin
			digits_out   <= display_pkg::bcd_digits_t'(acc[4*display_pkg::NUM_DIGITS-1:0]);
			overflow_out <= |acc[4*display_pkg::ACC_DIGITS-1 -: 4]; // fifth digit set
		end
	end

	assign out_bcd.digits   = digits_out;
	assign out_bcd.overflow = overflow_out;
	assign out_bcd.done     = done_pulse;
	assign out_bcd.busy     = busy;

endmodule

// ==== design/display_scanner.sv ====
// multiplexes four latched digits onto one set of segment lines
// blanks leading zeros and shows dashes when the value does not fit

`timescale 1ns/1ps

module display_scanner (
	input  logic CLK,
	input  logic reset,
	bcd_if.sink in_bcd,
	output display_pkg::seg_t segment,
	output logic [display_pkg::NUM_DIGITS-1:0] anode
);

	display_pkg::bcd_digits_t digits_latched; // digits on show
	logic overflow_latched;
	logic shown; // set after the first result arrives
	logic [display_pkg::SCAN_TICK_WIDTH-1:0] tick_count; // cycles in the current slot
	logic [display_pkg::DIGIT_INDEX_WIDTH-1:0] digit_index; // selected digit
	logic [display_pkg::NUM_DIGITS-1:0] lead_zero; // digit and all above it are zero
	display_pkg::bcd_digit_t digit_code; // decoder input after blanking
	display_pkg::seg_t digit_pattern;

	// scan timing runs from reset whether or not anything is shown
	always_ff @(posedge CLK) begin
		if (reset) begin
			tick_count  <= '0;
			digit_index <= '0;
			shown       <= 1'b0;
		end else begin
			if (tick_count == display_pkg::SCAN_TICK_WIDTH'(display_pkg::SCAN_TICKS - 1)) begin
				tick_count <= '0;
				if (digit_index ==
					display_pkg::DIGIT_INDEX_WIDTH'(display_pkg::NUM_DIGITS - 1)) begin
					digit_index <= '0;
				end else begin
					digit_index <= digit_index + 1'b1;
				end
			end else begin
				tick_count <= tick_count + 1'b1;
			end
			if (in_bcd.done) begin
				shown <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (in_bcd.done) begin
			digits_latched   <= in_bcd.digits;
			overflow_latched <= in_bcd.overflow;
		end
	end

	// digit 0 is never blanked, so a zero value still shows one digit
	always_comb begin
		logic all_zero;
		lead_zero[0] = 1'b0;
		for (int i = 1; i < display_pkg::NUM_DIGITS; i++) begin
			all_zero = 1'b1;
			for (int j = i; j < display_pkg::NUM_DIGITS; j++) begin
				if (digits_latched[j] != 4'd0) begin
					all_zero = 1'b0;
				end
			end
			lead_zero[i] = all_zero;
		end
	end

	always_comb begin
		if (lead_zero[digit_index]) begin
			digit_code = display_pkg::BCD_BLANK;
		end else begin
			digit_code = digits_latched[digit_index];
		end
	end

	seven_seg_decoder i_decoder (
		.digit   (digit_code),
		.pattern (digit_pattern)
	);

	always_comb begin
		anode = '0;
		if (shown) begin
			anode[digit_index] = 1'b1; // one-hot select
		end
	end

	always_comb begin
		if (!shown) begin
			segment = display_pkg::SEG_BLANK;
		end else if (overflow_latched) begin
			segment = display_pkg::SEG_DASH; // too large for four digits
		end else begin
			segment = digit_pattern;
		end
	end

endmodule

// ==== design/display_top.sv ====
// four digit seven-segment display top level
// value is loaded with a one-cycle strobe and accepted only while ready is high

`timescale 1ns/1ps

module display_top (
	input  logic CLK,
	input  logic reset,
	input  logic [display_pkg::VALUE_WIDTH-1:0] value,
	input  logic load,
	output display_pkg::seg_t segment,
	output logic [display_pkg::NUM_DIGITS-1:0] anode, // one-hot, digit 0 is least significant
	output logic ready
);

	bcd_if bcd_link ();

	bin2bcd_converter i_converter (
		.CLK     (CLK),
		.reset   (reset),
		.value   (value),
		.load    (load),
		.out_bcd (bcd_link.source)
	);

	display_scanner i_scanner (
		.CLK     (CLK),
		.reset   (reset),
		.in_bcd  (bcd_link.sink),
		.segment (segment),
		.anode   (anode)
	);

	assign ready = ~bcd_link.busy; // loads are dropped while converting

endmodule

// ==== tests/display_sva.sv ====
// concurrent checks on the scanner outputs
// attached to every display_scanner instance by the bind at the bottom

`timescale 1ns/1ps

module display_sva (
	input logic CLK,
	input logic reset,
	input display_pkg::seg_t segment,
	input logic [display_pkg::NUM_DIGITS-1:0] anode
);

	// at most one digit selected at a time
	a_anode_onehot: assert property (
		@(posedge CLK) disable iff (reset) $onehot0(anode)
	) else $error("anode select is not one-hot or zero: %b", anode);

	a_anode_after_reset: assert property (
		@(posedge CLK) reset |=> (anode == '0)
	) else $error("anode not zero in the cycle after reset: %b", anode);

	// nothing lit while no digit is selected
	a_blank_when_off: assert property (
		@(posedge CLK) disable iff (reset) (anode == '0) |-> (segment == display_pkg::SEG_BLANK)
	) else $error("segments lit with no digit selected: %b", segment);

endmodule

bind display_scanner display_sva i_sva (
	.CLK     (CLK),
	.reset   (reset),
	.segment (segment),
	.anode   (anode)
);

// ==== tests/tb_display_top.sv ====
// directed and random tests for the four digit display top level
// each test loads values and reads one full scan back from the segment lines

`timescale 1ns/1ps

module tb_display_top;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_RANDOM = 20;
	localparam int NUM_CHECKS = 1 + 6 + 3 + 1 + NUM_RANDOM; // reset, directed, overflow, drop, random
	localparam int CHECK_CYCLES = display_pkg::CONVERT_CYCLES + 4 * display_pkg::SCAN_TICKS + 20;
	localparam int WATCHDOG_CYCLES = 2 * NUM_CHECKS * CHECK_CYCLES; // doubled for margin
	localparam int IDLE_CYCLES = 3 * display_pkg::NUM_DIGITS * display_pkg::SCAN_TICKS; // three scans

	logic CLK;
	logic reset;
	logic [display_pkg::VALUE_WIDTH-1:0] value;
	logic load;
	display_pkg::seg_t segment;
	logic [display_pkg::NUM_DIGITS-1:0] anode;
	logic ready;

	int error_count;
	int tests_passed;
	int tests_failed;
	integer seed;

	display_top i_dut (
		.CLK     (CLK),
		.reset   (reset),
		.value   (value),
		.load    (load),
		.segment (segment),
		.anode   (anode),
		.ready   (ready)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// standard lit segments, bit 0 is a
	function automatic display_pkg::seg_t reference_pattern(input int unsigned digit);
		case (digit)
			0: return 7'h3f;
			1: return 7'h06;
			2: return 7'h5b;
			3: return 7'h4f;
			4: return 7'h66;
			5: return 7'h6d;
			6: return 7'h7d;
			7: return 7'h07;
			8: return 7'h7f;
			default: return 7'h6f;
		endcase
	endfunction

	function automatic display_pkg::seg_t expected_segment(input int unsigned v, input int idx);
		int unsigned place;
		place = 1;
		for (int i = 0; i < idx; i++) begin
			place = place * 10;
		end
		if (v > display_pkg::MAX_DISPLAY) begin
			return display_pkg::SEG_DASH;
		end
		if (idx > 0 && v < place) begin
			return display_pkg::SEG_BLANK; // this digit and all above are zero
		end
		return reference_pattern((v / place) % 10);
	endfunction

	task automatic load_value(input int unsigned v);
		@(posedge CLK);
		value <= v[display_pkg::VALUE_WIDTH-1:0];
		load  <= 1'b1;
		@(posedge CLK); // load accepted on this edge
		load  <= 1'b0;
	endtask

	// waits for the conversion, then samples the middle of each anode slot
	task automatic check_display(input int unsigned v);
		logic [display_pkg::NUM_DIGITS-1:0] prev_anode;
		display_pkg::seg_t expected;
		int idx;
		int last_idx;
		int waited;
		bit advanced;
		@(negedge CLK);
		waited = 0;
		while (!ready && waited < 4 * display_pkg::CONVERT_CYCLES) begin
			@(negedge CLK);
			waited++;
		end
		if (!ready) begin
			$display("ready did not return high after loading %0d", v);
			error_count++;
			return;
		end
		repeat (display_pkg::CONVERT_CYCLES + 2) @(negedge CLK);
		prev_anode = anode;
		last_idx = 0;
		for (int slot = 0; slot < display_pkg::NUM_DIGITS; slot++) begin
			advanced = 1'b0;
			for (int t = 0; t <= display_pkg::SCAN_TICKS && !advanced; t++) begin
				@(negedge CLK);
				if (anode != prev_anode) begin
					advanced = 1'b1;
				end
			end
			if (!advanced) begin
				$display("digit select stuck at %b while showing %0d", anode, v);
				error_count++;
				return;
			end
			prev_anode = anode;
			repeat (display_pkg::SCAN_TICKS / 2 - 1) @(negedge CLK); // middle of the slot
			if (!$onehot(anode)) begin
				$display("mismatch at %0t: anode expected one-hot, got %b", $time, anode);
				error_count++;
			end else begin
				idx = 0;
				for (int i = 0; i < display_pkg::NUM_DIGITS; i++) begin
					if (anode[i]) begin
						idx = i;
					end
				end
				// select steps 0, 1, 2, 3 and wraps
				if (slot > 0 && idx != (last_idx + 1) % display_pkg::NUM_DIGITS) begin
					$display("mismatch at %0t: anode expected digit %0d, got %b",
						$time, (last_idx + 1) % display_pkg::NUM_DIGITS, anode);
					error_count++;
				end
				last_idx = idx;
				expected = expected_segment(v, idx);
				if (segment !== expected) begin
					$display("mismatch at %0t: segment digit %0d of %0d expected %b, got %b",
						$time, idx, v, expected, segment);
					error_count++;
				end
			end
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("test %s done, no errors", name);
		end else begin
			tests_failed++;
			$display("test %s done, %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic idle_after_reset();
		int errors_before;
		bit failed;
		errors_before = error_count;
		failed = 1'b0;
		for (int n = 0; n < IDLE_CYCLES && !failed; n++) begin
			@(negedge CLK);
			if (ready !== 1'b1) begin
				$display("mismatch at %0t: ready expected 1, got %b", $time, ready);
				failed = 1'b1;
			end else if (anode !== '0) begin
				$display("mismatch at %0t: anode expected 0000, got %b", $time, anode);
				failed = 1'b1;
			end else if (segment !== display_pkg::SEG_BLANK) begin
				$display("mismatch at %0t: segment expected %b, got %b",
					$time, display_pkg::SEG_BLANK, segment);
				failed = 1'b1;
			end
		end
		if (failed) begin
			error_count++;
		end
		finish_test("idle_after_reset", errors_before);
	endtask

	task automatic directed_values();
		int unsigned values [6] = '{0, 7, 42, 305, 1234, 9999};
		int errors_before;
		errors_before = error_count;
		foreach (values[i]) begin
			load_value(values[i]);
			check_display(values[i]);
		end
		finish_test("directed_values", errors_before);
	endtask

	task automatic overflow_dashes();
		int unsigned values [3] = '{10000, 65535, 88}; // last one returns to digits
		int errors_before;
		errors_before = error_count;
		foreach (values[i]) begin
			load_value(values[i]);
			check_display(values[i]);
		end
		finish_test("overflow_dashes", errors_before);
	endtask

	// second load arrives mid-conversion and must be dropped
	task automatic dropped_load();
		int errors_before;
		errors_before = error_count;
		load_value(1234);
		for (int k = 0; k <= display_pkg::CONVERT_CYCLES; k++) begin
			@(negedge CLK);
			if (ready !== 1'b0) begin
				$display("mismatch at %0t: ready expected 0, got %b", $time, ready);
				error_count++;
			end
			if (k == 3) begin
				@(posedge CLK);
				value <= 16'd5678;
				load  <= 1'b1;
			end else if (k == 4) begin
				@(posedge CLK);
				load <= 1'b0;
			end
		end
		check_display(1234);
		finish_test("dropped_load", errors_before);
	endtask

	task automatic random_values();
		int unsigned v;
		int errors_before;
		errors_before = error_count;
		seed = 45256;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			v = $unsigned($random(seed)) & 32'h0000_ffff;
			load_value(v);
			check_display(v);
		end
		finish_test("random_values", errors_before);
	endtask

	initial begin
		value = '0;
		load  = 1'b0;
		reset = 1'b1;
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (5) @(posedge CLK);
		reset <= 1'b0;
		idle_after_reset();
		directed_values();
		overflow_dashes();
		dropped_load();
		random_values();
		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== seg_display.f ====
design/display_pkg.sv
design/bcd_if.sv
design/seven_seg_decoder.sv
design/bin2bcd_converter.sv
design/display_scanner.sv
design/display_top.sv
tests/display_sva.sv
tests/tb_display_top.sv

// ==== Makefile ====
# Verilator flow for the seven-segment display project
# make lint, make sim, make clean

TOP = tb_display_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f seg_display.f --top-module display_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f seg_display.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
